// ==== verilog/jtag_debug_pkg.sv ====
`default_nettype none

package jtag_debug_pkg;

	// Widths
	localparam int IR_WIDTH        = 4;
	localparam int ADDR_WIDTH      = 8;
	localparam int DATA_WIDTH      = 32;
	localparam int CNT_WIDTH       = 32;
	localparam int IBUF_WIDTH      = 4;
	localparam int PRBS_CTRL_WIDTH = 2;

	// Instruction codes, anything unlisted falls back to bypass
	localparam logic [IR_WIDTH-1:0] INSTR_IDCODE    = 4'h1;
	localparam logic [IR_WIDTH-1:0] INSTR_CFG_ADDR  = 4'h2;
	localparam logic [IR_WIDTH-1:0] INSTR_CFG_WRITE = 4'h3;
	localparam logic [IR_WIDTH-1:0] INSTR_CFG_READ  = 4'h4;
	localparam logic [IR_WIDTH-1:0] INSTR_BYPASS    = '1;

	localparam logic [IR_WIDTH-1:0] IR_CAPTURE      = 4'b0001;
	localparam logic [IR_WIDTH-1:0] TAP_RESET_INSTR = INSTR_IDCODE;

	// Bit 0 must stay set per IEEE 1149.1
	localparam logic [DATA_WIDTH-1:0] IDCODE_VALUE = 32'h4A7C_0F11;

	// Register map
	localparam logic [ADDR_WIDTH-1:0] ADDR_PRBS_CTRL = 8'h00;
	localparam logic [ADDR_WIDTH-1:0] ADDR_PRBS_INJ  = 8'h01;
	localparam logic [ADDR_WIDTH-1:0] ADDR_SCRATCH   = 8'h02;
	localparam logic [ADDR_WIDTH-1:0] ADDR_IBUF_DIS  = 8'h03;
	localparam logic [ADDR_WIDTH-1:0] ADDR_PRBS_ERR  = 8'h10;
	localparam logic [ADDR_WIDTH-1:0] ADDR_PRBS_BITS = 8'h11;

	// PRBS control bits
	localparam int PRBS_GEN_BIT = 0;
	localparam int PRBS_CHK_BIT = 1;

	// Reset values
	localparam logic [PRBS_CTRL_WIDTH-1:0] RST_PRBS_CTRL = '0;
	localparam logic [DATA_WIDTH-1:0]      RST_SCRATCH   = '0;
	localparam logic [IBUF_WIDTH-1:0]      RST_IBUF_DIS  = '1;

	// PRBS7, x^7 + x^6 + 1
	localparam int                     PRBS_ORDER = 7;
	localparam logic [PRBS_ORDER-1:0]  PRBS_SEED  = '1;

	// Bits dropped by the checker before it trusts its history
	localparam int PRBS_SYNC_BITS = 16;
	localparam int SYNC_CNT_WIDTH = $clog2(PRBS_SYNC_BITS + 1);

endpackage

`default_nettype wire

// ==== verilog/cfg_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cfg_bus_if;

	logic [jtag_debug_pkg::ADDR_WIDTH-1:0] addr;
	logic [jtag_debug_pkg::DATA_WIDTH-1:0] wdata;
	logic                                  wr_stb;
	// Combinational from addr
	logic [jtag_debug_pkg::DATA_WIDTH-1:0] rdata;

	modport tap (
		output addr,
		output wdata,
		output wr_stb,
		input  rdata
	);

	modport regs (
		input  addr,
		input  wdata,
		input  wr_stb,
		output rdata
	);

endinterface

`default_nettype wire

// ==== verilog/prbs_dbg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface prbs_dbg_if;

	logic                                 gen_en;
	logic                                 chk_en;
	// Single cycle pulse
	logic                                 inj_err;
	logic [jtag_debug_pkg::CNT_WIDTH-1:0] err_count;
	logic [jtag_debug_pkg::CNT_WIDTH-1:0] bit_count;

	modport regs (
		output gen_en,
		output chk_en,
		output inj_err,
		input  err_count,
		input  bit_count
	);

	modport bist (
		input  gen_en,
		input  chk_en,
		input  inj_err,
		output err_count,
		output bit_count
	);

endinterface

`default_nettype wire

// ==== verilog/jtag_tap.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_tap (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic     tdo_o,
	cfg_bus_if.tap   bus
);
	typedef enum logic [3:0] {
		TLR, RTI,
		SEL_DR, CAP_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPD_DR,
		SEL_IR, CAP_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPD_IR
	} tap_state_t;

	// Pin order is {trst_n, tdi, tms, tck}
	logic [3:0] pin_s1;
	logic [3:0] pin_s2;
	logic       tck_q;
	logic       tck_rise;
	logic       tck_fall;
	logic       tms_s;
	logic       tdi_s;
	logic       trst_n_s;

	tap_state_t state;
	tap_state_t state_nxt;

	logic [jtag_debug_pkg::IR_WIDTH-1:0]   ir;
	logic [jtag_debug_pkg::IR_WIDTH-1:0]   ir_shift;
	logic [jtag_debug_pkg::DATA_WIDTH-1:0] dr_shift;
	logic [jtag_debug_pkg::ADDR_WIDTH-1:0] addr_reg;
	logic                                  bypass_reg;
	logic                                  wr_stb;
	logic is_idcode, is_addr, is_write, is_read, is_bypass;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pin_s1 <= '0;
			pin_s2 <= '0;
			tck_q  <= 1'b0;
		end else begin
			pin_s1 <= {trst_n_i, tdi_i, tms_i, tck_i};
			pin_s2 <= pin_s1;
			tck_q  <= pin_s2[0];
		end
	end

	assign tck_rise = pin_s2[0] & ~tck_q;
	assign tck_fall = ~pin_s2[0] & tck_q;
	assign tms_s    = pin_s2[1];
	assign tdi_s    = pin_s2[2];
	assign trst_n_s = pin_s2[3];

	always_comb begin
		case (state)
			TLR:      state_nxt = tms_s ? TLR      : RTI;
			RTI:      state_nxt = tms_s ? SEL_DR   : RTI;
			SEL_DR:   state_nxt = tms_s ? SEL_IR   : CAP_DR;
			CAP_DR:   state_nxt = tms_s ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR: state_nxt = tms_s ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR: state_nxt = tms_s ? UPD_DR   : PAUSE_DR;
			PAUSE_DR: state_nxt = tms_s ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR: state_nxt = tms_s ? UPD_DR   : SHIFT_DR;
			UPD_DR:   state_nxt = tms_s ? SEL_DR   : RTI;
			SEL_IR:   state_nxt = tms_s ? TLR      : CAP_IR;
			CAP_IR:   state_nxt = tms_s ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR: state_nxt = tms_s ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR: state_nxt = tms_s ? UPD_IR   : PAUSE_IR;
			PAUSE_IR: state_nxt = tms_s ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR: state_nxt = tms_s ? UPD_IR   : SHIFT_IR;
			UPD_IR:   state_nxt = tms_s ? SEL_DR   : RTI;
			default:  state_nxt = TLR;
		endcase
	end

	always_comb begin
		is_idcode = 1'b0;
		is_addr   = 1'b0;
		is_write  = 1'b0;
		is_read   = 1'b0;
		is_bypass = 1'b0;
		case (ir)
			jtag_debug_pkg::INSTR_IDCODE:    is_idcode = 1'b1;
			jtag_debug_pkg::INSTR_CFG_ADDR:  is_addr   = 1'b1;
			jtag_debug_pkg::INSTR_CFG_WRITE: is_write  = 1'b1;
			jtag_debug_pkg::INSTR_CFG_READ:  is_read   = 1'b1;
			jtag_debug_pkg::INSTR_BYPASS:    is_bypass = 1'b1;
			default:                         is_bypass = 1'b1;
		endcase
	end

	// TRST_N only touches the controller, not the config address
	always_ff @(posedge clk) begin
		if (reset_i || !trst_n_s) begin
			state  <= TLR;
			ir     <= jtag_debug_pkg::TAP_RESET_INSTR;
			wr_stb <= 1'b0;
		end else begin
			wr_stb <= 1'b0;
			if (tck_rise) begin
				state <= state_nxt;
				if (state_nxt == TLR)
					ir <= jtag_debug_pkg::TAP_RESET_INSTR;
				else if (state_nxt == UPD_IR)
					ir <= ir_shift;
				if (state_nxt == UPD_DR && is_write)
					wr_stb <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			addr_reg <= '0;
		else if (tck_rise && state_nxt == UPD_DR && is_addr)
			addr_reg <= dr_shift[jtag_debug_pkg::ADDR_WIDTH-1:0];
	end

	// Capture acts on entry, shift on each rise spent in the shift state
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			if (state_nxt == CAP_IR)
				ir_shift <= jtag_debug_pkg::IR_CAPTURE;
			else if (state == SHIFT_IR)
				ir_shift <= {tdi_s, ir_shift[jtag_debug_pkg::IR_WIDTH-1:1]};

			if (state_nxt == CAP_DR) begin
				bypass_reg <= 1'b0;
				if (is_idcode)
					dr_shift <= jtag_debug_pkg::IDCODE_VALUE;
				else if (is_addr)
					dr_shift <= {{(jtag_debug_pkg::DATA_WIDTH -
						jtag_debug_pkg::ADDR_WIDTH){1'b0}}, addr_reg};
				else if (is_read)
					dr_shift <= bus.rdata;
			end else if (state == SHIFT_DR) begin
				bypass_reg <= tdi_s;
				// Address register is only 8 bits long
				if (is_addr)
					dr_shift[jtag_debug_pkg::ADDR_WIDTH-1:0] <=
						{tdi_s, dr_shift[jtag_debug_pkg::ADDR_WIDTH-1:1]};
				else
					dr_shift <= {tdi_s, dr_shift[jtag_debug_pkg::DATA_WIDTH-1:1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall) begin
			if (state == SHIFT_IR)
				tdo_o <= ir_shift[0];
			else if (state == SHIFT_DR)
				tdo_o <= is_bypass ? bypass_reg : dr_shift[0];
			else
				tdo_o <= 1'b0;
		end
	end

	assign bus.addr   = addr_reg;
	assign bus.wdata  = dr_shift;
	assign bus.wr_stb = wr_stb;

endmodule

`default_nettype wire

// ==== verilog/cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
	input wire logic clk,
	input wire logic reset_i,
	cfg_bus_if.regs  bus,
	prbs_dbg_if.regs prbs,
	output logic [jtag_debug_pkg::IBUF_WIDTH-1:0] disable_ibuf_o
);
	logic [jtag_debug_pkg::PRBS_CTRL_WIDTH-1:0] prbs_ctrl;
	logic [jtag_debug_pkg::DATA_WIDTH-1:0]      scratch;
	logic [jtag_debug_pkg::IBUF_WIDTH-1:0]      ibuf_dis;
	logic                                       inj_err_q;
	logic                                       inj_hit;

	assign inj_hit = bus.wr_stb && (bus.addr == jtag_debug_pkg::ADDR_PRBS_INJ);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			prbs_ctrl <= jtag_debug_pkg::RST_PRBS_CTRL;
			scratch   <= jtag_debug_pkg::RST_SCRATCH;
			ibuf_dis  <= jtag_debug_pkg::RST_IBUF_DIS;
			inj_err_q <= 1'b0;
		end else begin
			// Write data itself is ignored for the inject address
			inj_err_q <= inj_hit;
			if (bus.wr_stb) begin
				case (bus.addr)
					jtag_debug_pkg::ADDR_PRBS_CTRL:
						prbs_ctrl <= bus.wdata[jtag_debug_pkg::PRBS_CTRL_WIDTH-1:0];
					jtag_debug_pkg::ADDR_SCRATCH:
						scratch <= bus.wdata;
					jtag_debug_pkg::ADDR_IBUF_DIS:
						ibuf_dis <= bus.wdata[jtag_debug_pkg::IBUF_WIDTH-1:0];
					default: ;
				endcase
			end
		end
	end

	// Read back, unmapped and write-only addresses return zero
	always_comb begin
		bus.rdata = '0;
		case (bus.addr)
			jtag_debug_pkg::ADDR_PRBS_CTRL:
				bus.rdata[jtag_debug_pkg::PRBS_CTRL_WIDTH-1:0] = prbs_ctrl;
			jtag_debug_pkg::ADDR_SCRATCH:
				bus.rdata = scratch;
			jtag_debug_pkg::ADDR_IBUF_DIS:
				bus.rdata[jtag_debug_pkg::IBUF_WIDTH-1:0] = ibuf_dis;
			jtag_debug_pkg::ADDR_PRBS_ERR:
				bus.rdata = prbs.err_count;
			jtag_debug_pkg::ADDR_PRBS_BITS:
				bus.rdata = prbs.bit_count;
			default:
				bus.rdata = '0;
		endcase
	end

	// Status and control mapping to the PRBS block
	assign prbs.gen_en  = prbs_ctrl[jtag_debug_pkg::PRBS_GEN_BIT];
	assign prbs.chk_en  = prbs_ctrl[jtag_debug_pkg::PRBS_CHK_BIT];
	assign prbs.inj_err = inj_err_q;

	assign disable_ibuf_o = ibuf_dis;

endmodule

`default_nettype wire

// ==== verilog/prbs_bist.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_bist (
	input wire logic clk,
	input wire logic reset_i,
	prbs_dbg_if.bist prbs,
	output logic     prbs_o,
	input wire logic prbs_i
);
	localparam int N = jtag_debug_pkg::PRBS_ORDER;

	logic [N-1:0] gen_lfsr;
	logic         gen_bit;

	logic [N-1:0]                              chk_hist;
	logic                                      chk_pred;
	logic [jtag_debug_pkg::SYNC_CNT_WIDTH-1:0] sync_cnt;
	logic                                      chk_locked;

	// Generator, taps at x^7 and x^6
	assign gen_bit = gen_lfsr[N-1] ^ gen_lfsr[N-2];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			gen_lfsr <= jtag_debug_pkg::PRBS_SEED;
			prbs_o   <= 1'b0;
		end else if (prbs.gen_en) begin
			gen_lfsr <= {gen_lfsr[N-2:0], gen_bit};
			// Error only on the line, LFSR keeps the clean sequence
			prbs_o   <= gen_bit ^ prbs.inj_err;
		end
	end

	// Checker predicts from received bits, so it locks onto any phase
	assign chk_pred   = chk_hist[N-1] ^ chk_hist[N-2];
	assign chk_locked = (sync_cnt == jtag_debug_pkg::SYNC_CNT_WIDTH'(
		jtag_debug_pkg::PRBS_SYNC_BITS));

	always_ff @(posedge clk) begin
		if (reset_i) begin
			chk_hist       <= '0;
			sync_cnt       <= '0;
			prbs.err_count <= '0;
			prbs.bit_count <= '0;
		end else if (!prbs.chk_en) begin
			sync_cnt <= '0;
		end else begin
			chk_hist <= {chk_hist[N-2:0], prbs_i};
			if (!chk_locked) begin
				sync_cnt <= sync_cnt + 1'b1;
			end else begin
				prbs.bit_count <= prbs.bit_count + 1'b1;
				// One flipped bit hits now and at taps 6 and 7 later
				if (prbs_i != chk_pred)
					prbs.err_count <= prbs.err_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/jtag_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_debug_top (
	input wire logic clk,
	input wire logic reset_i,

	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic     tdo_o,

	output logic     prbs_o,
	input wire logic prbs_i,

	output logic [jtag_debug_pkg::IBUF_WIDTH-1:0] disable_ibuf_o
);
	cfg_bus_if  u_cfg_bus ();
	prbs_dbg_if u_prbs_dbg ();

	jtag_tap u_tap (
		.clk      (clk),
		.reset_i  (reset_i),
		.tck_i    (tck_i),
		.tms_i    (tms_i),
		.tdi_i    (tdi_i),
		.trst_n_i (trst_n_i),
		.tdo_o    (tdo_o),
		.bus      (u_cfg_bus.tap)
	);

	cfg_regs u_regs (
		.clk            (clk),
		.reset_i        (reset_i),
		.bus            (u_cfg_bus.regs),
		.prbs           (u_prbs_dbg.regs),
		.disable_ibuf_o (disable_ibuf_o)
	);

	prbs_bist u_prbs (
		.clk     (clk),
		.reset_i (reset_i),
		.prbs    (u_prbs_dbg.bist),
		.prbs_o  (prbs_o),
		.prbs_i  (prbs_i)
	);

endmodule

`default_nettype wire

// ==== tests/tb_jtag_debug.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_debug;

	localparam int TCK_HALF = 4;
	// Roughly 3800 TCK periods of 8 clk each with margin on top
	localparam int TIMEOUT_CYCLES = 40000;

	logic clk;
	logic reset_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic tdo_o;
	logic prbs_o;
	logic prbs_i;
	logic flip;
	logic [jtag_debug_pkg::IBUF_WIDTH-1:0] disable_ibuf_o;

	integer seed;
	int     cycle_cnt = 0;
	logic [jtag_debug_pkg::IR_WIDTH-1:0]   cur_ir;
	logic [jtag_debug_pkg::ADDR_WIDTH-1:0] cur_addr;

	// Register map model
	logic [jtag_debug_pkg::PRBS_CTRL_WIDTH-1:0] m_ctrl;
	logic [jtag_debug_pkg::DATA_WIDTH-1:0]      m_scratch;
	logic [jtag_debug_pkg::IBUF_WIDTH-1:0]      m_ibuf;
	logic [jtag_debug_pkg::CNT_WIDTH-1:0]       m_err;

	// Pending compares
	string       name_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] act_q[$];
	string       cmp_name;
	logic [31:0] cmp_exp;
	logic [31:0] cmp_act;

	// Loopback with a one-cycle error flip
	assign prbs_i = prbs_o ^ flip;

	jtag_debug_top u_dut (
		.clk            (clk),
		.reset_i        (reset_i),
		.tck_i          (tck_i),
		.tms_i          (tms_i),
		.tdi_i          (tdi_i),
		.trst_n_i       (trst_n_i),
		.tdo_o          (tdo_o),
		.prbs_o         (prbs_o),
		.prbs_i         (prbs_i),
		.disable_ibuf_o (disable_ibuf_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("Timeout: test sequence did not finish within the cycle limit");
	end

	always @(posedge clk) begin
		while (exp_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_act  = act_q.pop_front();
			assert (cmp_act === cmp_exp) else
				abort_run($sformatf("ERR %s expected 0x%08h got 0x%08h",
					cmp_name, cmp_exp, cmp_act));
		end
	end

	function automatic void post_check(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endfunction

	function automatic void model_reset();
		m_ctrl    = jtag_debug_pkg::RST_PRBS_CTRL;
		m_scratch = jtag_debug_pkg::RST_SCRATCH;
		m_ibuf    = jtag_debug_pkg::RST_IBUF_DIS;
		m_err     = '0;
	endfunction

	function automatic void model_write(input logic [7:0] a, input logic [31:0] d);
		case (a)
			jtag_debug_pkg::ADDR_PRBS_CTRL: m_ctrl = d[jtag_debug_pkg::PRBS_CTRL_WIDTH-1:0];
			jtag_debug_pkg::ADDR_SCRATCH:   m_scratch = d;
			jtag_debug_pkg::ADDR_IBUF_DIS:  m_ibuf = d[jtag_debug_pkg::IBUF_WIDTH-1:0];
			// One flipped bit costs three mismatches once the checker is locked
			jtag_debug_pkg::ADDR_PRBS_INJ:
				if (m_ctrl == 2'b11)
					m_err = m_err + 3;
			default: ;
		endcase
	endfunction

	// Only the reset value of the free running bit counter is modelled
	function automatic logic [31:0] model_read(input logic [7:0] a);
		logic [31:0] rd;
		rd = '0;
		case (a)
			jtag_debug_pkg::ADDR_PRBS_CTRL: rd[jtag_debug_pkg::PRBS_CTRL_WIDTH-1:0] = m_ctrl;
			jtag_debug_pkg::ADDR_SCRATCH:   rd = m_scratch;
			jtag_debug_pkg::ADDR_IBUF_DIS:  rd[jtag_debug_pkg::IBUF_WIDTH-1:0] = m_ibuf;
			jtag_debug_pkg::ADDR_PRBS_ERR:  rd = m_err;
			default: ;
		endcase
		return rd;
	endfunction

	// PRBS7 step for x^7 + x^6 + 1 with the newest bit in the LSB
	function automatic logic [6:0] prbs7_next(input logic [6:0] s);
		return {s[5:0], s[6] ^ s[5]};
	endfunction

	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		@(negedge clk);
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		repeat (TCK_HALF) @(negedge clk);
		// TDO settled after the falling TCK edge
		tdo = tdo_o;
		tck_i = 1'b1;
		repeat (TCK_HALF - 1) @(negedge clk);
	endtask

	task automatic tap_reset();
		logic b;
		repeat (5) tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		cur_ir = jtag_debug_pkg::TAP_RESET_INSTR;
	endtask

	// Starts and ends in Run-Test/Idle
	task automatic scan_reg(input logic is_ir, input logic [31:0] din, input int n,
		output logic [31:0] dout);
		logic b;
		dout = '0;
		tck_cycle(1'b1, 1'b0, b);
		if (is_ir)
			tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < n; i++) begin
			tck_cycle(i == n - 1, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic set_ir(input logic [3:0] code);
		logic [31:0] unused;
		if (code != cur_ir) begin
			scan_reg(1'b1, {28'b0, code}, jtag_debug_pkg::IR_WIDTH, unused);
			cur_ir = code;
		end
	endtask

	task automatic set_addr(input logic [7:0] a);
		logic [31:0] unused;
		if (a != cur_addr) begin
			set_ir(jtag_debug_pkg::INSTR_CFG_ADDR);
			scan_reg(1'b0, {24'b0, a}, jtag_debug_pkg::ADDR_WIDTH, unused);
			cur_addr = a;
		end
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
		logic [31:0] unused;
		set_addr(a);
		set_ir(jtag_debug_pkg::INSTR_CFG_WRITE);
		scan_reg(1'b0, d, jtag_debug_pkg::DATA_WIDTH, unused);
		model_write(a, d);
	endtask

	task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
		set_addr(a);
		set_ir(jtag_debug_pkg::INSTR_CFG_READ);
		scan_reg(1'b0, 32'h0, jtag_debug_pkg::DATA_WIDTH, d);
	endtask

	task automatic check_reg(input logic [7:0] a);
		logic [31:0] d;
		read_reg(a, d);
		post_check($sformatf("rdata@%02h", a), model_read(a), d);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] b1;
		logic [31:0] b2;
		logic        b;
		logic [6:0]  st;
		seed     = 40645;
		tck_i    = 1'b0;
		tms_i    = 1'b1;
		tdi_i    = 1'b0;
		trst_n_i = 1'b1;
		flip     = 1'b0;
		reset_i  = 1'b1;
		cur_ir   = jtag_debug_pkg::TAP_RESET_INSTR;
		cur_addr = '0;
		model_reset();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		post_check("disable_ibuf_o", m_ibuf, disable_ibuf_o);

		// IDCODE after reset and after a tap reset followed by IR capture and bypass
		tck_cycle(1'b0, 1'b0, b);
		scan_reg(1'b0, $random(seed), 32, d);
		post_check("idcode", jtag_debug_pkg::IDCODE_VALUE, d);
		// Leave IDCODE so the tap reset has to restore it
		set_ir(jtag_debug_pkg::INSTR_BYPASS);
		tap_reset();
		scan_reg(1'b0, $random(seed), 32, d);
		post_check("idcode", jtag_debug_pkg::IDCODE_VALUE, d);
		r = $random(seed);
		scan_reg(1'b1, {24'b0, jtag_debug_pkg::INSTR_BYPASS, r[3:0]}, 8, d);
		cur_ir = jtag_debug_pkg::INSTR_BYPASS;
		post_check("ir_out", {24'b0, r[3:0], jtag_debug_pkg::IR_CAPTURE}, d);
		r = $random(seed);
		scan_reg(1'b0, r, 32, d);
		post_check("bypass", {r[30:0], 1'b0}, d);

		check_reg(jtag_debug_pkg::ADDR_PRBS_CTRL);
		check_reg(jtag_debug_pkg::ADDR_SCRATCH);
		check_reg(jtag_debug_pkg::ADDR_IBUF_DIS);
		check_reg(jtag_debug_pkg::ADDR_PRBS_ERR);
		check_reg(jtag_debug_pkg::ADDR_PRBS_BITS);
		repeat (20) begin
			write_reg(jtag_debug_pkg::ADDR_SCRATCH, $random(seed));
			check_reg(jtag_debug_pkg::ADDR_SCRATCH);
		end
		check_reg(8'h5A);

		repeat (4) begin
			write_reg(jtag_debug_pkg::ADDR_IBUF_DIS, $random(seed));
			post_check("disable_ibuf_o", m_ibuf, disable_ibuf_o);
		end

		// Seed the reference from the first seven bits seen after enable
		write_reg(jtag_debug_pkg::ADDR_PRBS_CTRL, 32'h1);
		st = '0;
		repeat (7) begin
			@(negedge clk);
			st = {st[5:0], prbs_o};
		end
		assert (st != '0) else abort_run("PRBS output stuck at zero after enable");
		repeat (64) begin
			st = prbs7_next(st);
			@(negedge clk);
			post_check("prbs_o", st[0], prbs_o);
		end

		write_reg(jtag_debug_pkg::ADDR_PRBS_CTRL, 32'h3);
		check_reg(jtag_debug_pkg::ADDR_PRBS_ERR);
		read_reg(jtag_debug_pkg::ADDR_PRBS_BITS, b1);
		read_reg(jtag_debug_pkg::ADDR_PRBS_BITS, b2);
		assert (b2 > b1) else abort_run("PRBS bit counter did not advance between reads");
		repeat (3) begin
			write_reg(jtag_debug_pkg::ADDR_PRBS_INJ, $random(seed));
			check_reg(jtag_debug_pkg::ADDR_PRBS_ERR);
		end

		@(negedge clk);
		flip = 1'b1;
		@(negedge clk);
		flip = 1'b0;
		m_err = m_err + 3;
		check_reg(jtag_debug_pkg::ADDR_PRBS_ERR);

		// TRST in the middle of a write shift so the write never lands
		set_addr(jtag_debug_pkg::ADDR_SCRATCH);
		set_ir(jtag_debug_pkg::INSTR_CFG_WRITE);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		repeat (10) begin
			r = $random(seed);
			tck_cycle(1'b0, r[0], b);
		end
		@(negedge clk);
		trst_n_i = 1'b0;
		repeat (2 * TCK_HALF) @(negedge clk);
		trst_n_i = 1'b1;
		cur_ir = jtag_debug_pkg::TAP_RESET_INSTR;
		tck_cycle(1'b0, 1'b0, b);
		scan_reg(1'b0, $random(seed), 32, d);
		post_check("idcode", jtag_debug_pkg::IDCODE_VALUE, d);
		check_reg(jtag_debug_pkg::ADDR_PRBS_CTRL);
		check_reg(jtag_debug_pkg::ADDR_SCRATCH);
		check_reg(jtag_debug_pkg::ADDR_IBUF_DIS);
		check_reg(jtag_debug_pkg::ADDR_PRBS_ERR);

		// Let the compare process drain
		@(posedge clk);
		@(negedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== jtag_debug.f ====
verilog/jtag_debug_pkg.sv
verilog/cfg_bus_if.sv
verilog/prbs_dbg_if.sv
verilog/jtag_tap.sv
verilog/cfg_regs.sv
verilog/prbs_bist.sv
verilog/jtag_debug_top.sv
tests/tb_jtag_debug.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_jtag_debug \
	-f jtag_debug.f -Mdir obj_dir -o tb_jtag_debug
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_jtag_debug)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
